/* common/tomasulo_pkg.sv */
`default_nettype none

package tomasulo_pkg;

    // ####################
    // Sizes
    // ####################
    localparam int data_width = 32;
    localparam int tag_width = 4;   // Tag 0 means no dependency.
    localparam int rs_size = 8;
    localparam int lsb_depth = 4;
    localparam int mem_words = 16;

    localparam int rs_idx_width = $clog2(rs_size);
    localparam int lsb_ptr_width = $clog2(lsb_depth);
    localparam int lsb_count_width = $clog2(lsb_depth) + 1;
    localparam int mem_addr_width = $clog2(mem_words);

    typedef logic [tag_width-1:0] rob_tag_t;
    typedef logic [data_width-1:0] data_t;

    // ####################
    // Op codes
    // ####################
    typedef enum logic {
        class_alu = 1'b0,
        class_mem = 1'b1
    } op_class_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,
        alu_srl = 3'd6,
        alu_slt = 3'd7
    } alu_func_t;

    typedef enum logic {
        mem_load  = 1'b0,
        mem_store = 1'b1
    } mem_func_t;

    typedef struct packed {
        logic [1:0] spare;  // Kept zero.
        mem_func_t  func;
    } mem_code_t;

    // Meaning depends on the op class.
    typedef union packed {
        alu_func_t alu;
        mem_code_t mem;
    } op_code_u;

    // ####################
    // Transfers
    // ####################
    typedef struct packed {
        rob_tag_t  rob_tag;
        op_class_t op_class;
        op_code_u  op;
        data_t     rs1_val;
        rob_tag_t  rs1_tag;
        data_t     rs2_val;
        rob_tag_t  rs2_tag;
        data_t     imm;
        data_t     pc;
    } issue_entry_t;

    typedef struct packed {
        rob_tag_t rob_tag;
        op_code_u op;
        data_t    rs1;
        data_t    rs2;
        data_t    imm;
        data_t    pc;
    } exec_req_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t rob_tag;
        data_t    result;
    } cdb_t;

endpackage

`default_nettype wire

/* reservation_station/reservation_station.sv */
`timescale 1ns/1ps
`default_nettype none

module reservation_station import tomasulo_pkg::*; (
    input  logic         clk_in,
    input  logic         reset,
    input  logic         flush,
    input  logic         issue_valid,
    input  issue_entry_t issue,
    output logic         issue_ready,
    input  cdb_t         cdb,
    output logic         alu_req_valid,
    output exec_req_t    alu_req,
    input  logic         alu_req_ready,
    output logic         mem_req_valid,
    output exec_req_t    mem_req,
    input  logic         mem_req_ready
);

    issue_entry_t entries [rs_size];
    issue_entry_t woken [rs_size];
    issue_entry_t issue_woken;
    logic [rs_size-1:0] busy;
    logic [rs_size-1:0] in_flight;     // Copied into a dispatch register.
    logic [rs_size-1:0] alu_ready_vec;
    logic [rs_size-1:0] mem_ready_vec;
    logic [rs_idx_width-1:0] free_idx;
    logic [rs_idx_width-1:0] alu_pick;
    logic [rs_idx_width-1:0] mem_pick;
    logic [rs_idx_width-1:0] alu_idx;
    logic [rs_idx_width-1:0] mem_idx;
    logic issue_fire;
    logic alu_fire;
    logic mem_fire;
    logic alu_load;
    logic mem_load;

    // Apply a CDB broadcast to both operands.
    function automatic issue_entry_t wake(issue_entry_t e, cdb_t c);
        issue_entry_t w;
        w = e;
        if (c.valid && e.rs1_tag != '0 && e.rs1_tag == c.rob_tag) begin
            w.rs1_val = c.result;
            w.rs1_tag = '0;
        end
        if (c.valid && e.rs2_tag != '0 && e.rs2_tag == c.rob_tag) begin
            w.rs2_val = c.result;
            w.rs2_tag = '0;
        end
        return w;
    endfunction

    function automatic exec_req_t to_exec(issue_entry_t e);
        exec_req_t r;
        r.rob_tag = e.rob_tag;
        r.op = e.op;
        r.rs1 = e.rs1_val;
        r.rs2 = e.rs2_val;
        r.imm = e.imm;
        r.pc = e.pc;
        return r;
    endfunction

    // ####################
    // Wakeup and search
    // ####################
    assign issue_woken = wake(issue, cdb);

    always_comb begin
        for (int i = 0; i < rs_size; i++) begin
            woken[i] = wake(entries[i], cdb);
            alu_ready_vec[i] = busy[i] && !in_flight[i] && woken[i].rs1_tag == '0
                               && woken[i].rs2_tag == '0 && woken[i].op_class == class_alu;
            mem_ready_vec[i] = busy[i] && !in_flight[i] && woken[i].rs1_tag == '0
                               && woken[i].rs2_tag == '0 && woken[i].op_class == class_mem;
        end
    end

    // Walk downward so the lowest index wins.
    always_comb begin
        free_idx = '0;
        alu_pick = '0;
        mem_pick = '0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            if (!busy[i]) free_idx = rs_idx_width'(i);
            if (alu_ready_vec[i]) alu_pick = rs_idx_width'(i);
            if (mem_ready_vec[i]) mem_pick = rs_idx_width'(i);
        end
    end

    assign issue_ready = ~&busy;
    assign issue_fire = issue_valid && issue_ready;
    assign alu_fire = alu_req_valid && alu_req_ready;
    assign mem_fire = mem_req_valid && mem_req_ready;
    assign alu_load = |alu_ready_vec && (!alu_req_valid || alu_req_ready);
    assign mem_load = |mem_ready_vec && (!mem_req_valid || mem_req_ready);

    // ####################
    // Control state
    // ####################
    always_ff @(posedge clk_in) begin
        if (reset || flush) begin
            busy <= '0;
            in_flight <= '0;
            alu_req_valid <= 1'b0;
            mem_req_valid <= 1'b0;
            alu_idx <= '0;
            mem_idx <= '0;
        end else begin
            if (alu_fire) begin  // Entry leaves on handover.
                busy[alu_idx] <= 1'b0;
                in_flight[alu_idx] <= 1'b0;
            end
            if (mem_fire) begin
                busy[mem_idx] <= 1'b0;
                in_flight[mem_idx] <= 1'b0;
            end
            if (alu_load) begin
                in_flight[alu_pick] <= 1'b1;
                alu_idx <= alu_pick;
                alu_req_valid <= 1'b1;
            end else if (alu_fire) begin
                alu_req_valid <= 1'b0;
            end
            if (mem_load) begin
                in_flight[mem_pick] <= 1'b1;
                mem_idx <= mem_pick;
                mem_req_valid <= 1'b1;
            end else if (mem_fire) begin
                mem_req_valid <= 1'b0;
            end
            if (issue_fire) busy[free_idx] <= 1'b1;
        end
    end

    // Payload.
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < rs_size; i++) begin
            if (busy[i]) entries[i] <= woken[i];
        end
        if (issue_fire) entries[free_idx] <= issue_woken;
        if (alu_load) alu_req <= to_exec(woken[alu_pick]);
        if (mem_load) mem_req <= to_exec(woken[mem_pick]);
    end

endmodule

`default_nettype wire

/* design/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit import tomasulo_pkg::*; (
    input  logic      clk_in,
    input  logic      reset,
    input  logic      flush,
    input  logic      req_valid,
    input  exec_req_t req,
    output logic      req_ready,
    output logic      cdb_req,
    output cdb_t      result,
    input  logic      grant
);

    logic held;
    rob_tag_t held_tag;
    data_t held_value;
    data_t alu_out;
    logic accept;

    always_comb begin
        case (req.op.alu)
            alu_add: alu_out = req.rs1 + req.rs2;
            alu_sub: alu_out = req.rs1 - req.rs2;
            alu_and: alu_out = req.rs1 & req.rs2;
            alu_or:  alu_out = req.rs1 | req.rs2;
            alu_xor: alu_out = req.rs1 ^ req.rs2;
            alu_sll: alu_out = req.rs1 << req.rs2[4:0];
            alu_srl: alu_out = req.rs1 >> req.rs2[4:0];
            alu_slt: alu_out = data_t'($signed(req.rs1) < $signed(req.rs2));
            default: alu_out = '0;
        endcase
    end

    // Holder frees up in the cycle it wins the bus.
    assign req_ready = !held || grant;
    assign accept = req_valid && req_ready;

    always_ff @(posedge clk_in) begin
        if (reset || flush) begin
            held <= 1'b0;
        end else if (accept) begin
            held <= 1'b1;
        end else if (grant) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            held_tag <= req.rob_tag;
            held_value <= alu_out;
        end
    end

    assign cdb_req = held;
    assign result = '{valid: held, rob_tag: held_tag, result: held_value};

endmodule

`default_nettype wire

/* design/load_store_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_buffer import tomasulo_pkg::*; (
    input  logic      clk_in,
    input  logic      reset,
    input  logic      flush,
    input  logic      req_valid,
    input  exec_req_t req,
    output logic      req_ready,
    output logic      cdb_req,
    output cdb_t      result,
    input  logic      grant
);

    exec_req_t queue [lsb_depth];
    data_t mem [mem_words];
    logic [lsb_ptr_width-1:0] head_ptr;
    logic [lsb_ptr_width-1:0] tail_ptr;
    logic [lsb_count_width-1:0] count;
    exec_req_t head;
    data_t head_sum;
    logic [mem_addr_width-1:0] head_addr;
    logic is_store;
    logic push;
    logic pop;
    logic held;
    rob_tag_t held_tag;
    data_t held_value;

    // ####################
    // Queue
    // ####################
    assign req_ready = count < lsb_depth;
    assign push = req_valid && req_ready;
    assign pop = count != '0 && (!held || grant);  // Head moves to holder.

    assign head = queue[head_ptr];
    assign head_sum = head.rs1 + head.imm;
    assign head_addr = head_sum[mem_addr_width-1:0];  // Word index.
    assign is_store = head.op.mem.func == mem_store;

    always_ff @(posedge clk_in) begin
        if (reset || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count <= '0;
        end else begin
            if (push) tail_ptr <= tail_ptr + 1'b1;
            if (pop) head_ptr <= head_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (push) queue[tail_ptr] <= req;
    end

    // ####################
    // Memory and holder
    // ####################
    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (pop && is_store) begin
            mem[head_addr] <= head.rs2;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset || flush) begin
            held <= 1'b0;
        end else if (pop) begin
            held <= 1'b1;
        end else if (grant) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (pop) begin
            held_tag <= head.rob_tag;
            held_value <= is_store ? '0 : mem[head_addr];  // Stores report 0.
        end
    end

    assign cdb_req = held;
    assign result = '{valid: held, rob_tag: held_tag, result: held_value};

endmodule

`default_nettype wire

/* design/cdb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter import tomasulo_pkg::*; (
    input  logic clk_in,
    input  logic reset,
    input  logic alu_req,
    input  cdb_t alu_result,
    input  logic lsb_req,
    input  cdb_t lsb_result,
    output logic alu_grant,
    output logic lsb_grant,
    output cdb_t cdb
);

    logic lsb_first;  // Low favours the ALU.

    assign alu_grant = alu_req && (!lsb_req || !lsb_first);
    assign lsb_grant = lsb_req && (!alu_req || lsb_first);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            lsb_first <= 1'b0;
        end else if (alu_grant) begin
            lsb_first <= 1'b1;
        end else if (lsb_grant) begin
            lsb_first <= 1'b0;
        end
    end

    always_comb begin
        if (alu_grant) begin
            cdb = alu_result;
        end else if (lsb_grant) begin
            cdb = lsb_result;
        end else begin
            cdb = '0;  // Bus idle.
        end
    end

endmodule

`default_nettype wire

/* design/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core import tomasulo_pkg::*; (
    input  logic         clk_in,
    input  logic         reset,
    input  logic         flush,
    input  logic         issue_valid,
    input  issue_entry_t issue,
    output logic         issue_ready,
    output cdb_t         cdb
);

    logic alu_req_valid;
    exec_req_t alu_req;
    logic alu_req_ready;
    logic mem_req_valid;
    exec_req_t mem_req;
    logic mem_req_ready;
    logic alu_cdb_req;
    cdb_t alu_result;
    logic alu_grant;
    logic lsb_cdb_req;
    cdb_t lsb_result;
    logic lsb_grant;

    reservation_station u_rs (
        .clk_in        (clk_in),
        .reset         (reset),
        .flush         (flush),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .issue_ready   (issue_ready),
        .cdb           (cdb),
        .alu_req_valid (alu_req_valid),
        .alu_req       (alu_req),
        .alu_req_ready (alu_req_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready)
    );

    alu_unit u_alu (
        .clk_in    (clk_in),
        .reset     (reset),
        .flush     (flush),
        .req_valid (alu_req_valid),
        .req       (alu_req),
        .req_ready (alu_req_ready),
        .cdb_req   (alu_cdb_req),
        .result    (alu_result),
        .grant     (alu_grant)
    );

    load_store_buffer u_lsb (
        .clk_in    (clk_in),
        .reset     (reset),
        .flush     (flush),
        .req_valid (mem_req_valid),
        .req       (mem_req),
        .req_ready (mem_req_ready),
        .cdb_req   (lsb_cdb_req),
        .result    (lsb_result),
        .grant     (lsb_grant)
    );

    // Flush also returns priority to the ALU.
    cdb_arbiter u_arb (
        .clk_in     (clk_in),
        .reset      (reset || flush),
        .alu_req    (alu_cdb_req),
        .alu_result (alu_result),
        .lsb_req    (lsb_cdb_req),
        .lsb_result (lsb_result),
        .alu_grant  (alu_grant),
        .lsb_grant  (lsb_grant),
        .cdb        (cdb)
    );

endmodule

`default_nettype wire

/* sim/tb_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core import tomasulo_pkg::*; ();

    localparam int value_ops = 40;
    localparam int chain_ops = 60;
    localparam int memory_ops = 60;
    localparam int mixed_ops = 80;
    localparam int after_ops = 60;
    localparam int total_ops = value_ops + chain_ops + memory_ops + mixed_ops + rs_size + 1
                               + after_ops;
    localparam int timeout_limit = 40 * total_ops + 500;

    logic clk_in;
    logic reset;
    logic flush;
    logic issue_valid;
    issue_entry_t issue;
    logic issue_ready;
    cdb_t cdb;

    logic [31:0] lfsr_state;
    data_t tag_value [16];        // Expected result per tag.
    logic [15:0] tag_pending;
    logic [15:0] tag_is_mem;
    logic [3:0] tag_addr [16];
    logic [15:0] addr_busy;       // Word has a memory op in flight.
    data_t mem_model [16];
    rob_tag_t last_tag;
    int value_errors;
    int tag_errors;
    int other_errors;
    int issued;
    int completed;
    int cycle_count;

    exec_core uut (
        .clk_in      (clk_in),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .cdb         (cdb)
    );

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        if (!reset) cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count > timeout_limit);
        $display("Timeout after %0d cycles with %0d of %0d ops completed",
                 cycle_count, completed, issued);
        $display("** FAIL **");
        $finish;
    end

    // ####################
    // Random source
    // ####################
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = galois_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};  // One step per bit.
        end
        return v;
    endfunction

    // ####################
    // Reference model
    // ####################
    function automatic data_t alu_expect(input alu_func_t f, input data_t a, input data_t b);
        case (f)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_sll: return a << b[4:0];
            alu_srl: return a >> b[4:0];
            default: return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
        endcase
    endfunction

    function automatic rob_tag_t free_tag();
        rob_tag_t t;
        t = '0;
        for (int i = 15; i >= 1; i--) begin
            if (!tag_pending[i]) t = rob_tag_t'(i);
        end
        return t;
    endfunction

    // Producers that have broadcast turn into plain values.
    function automatic issue_entry_t resolve(input issue_entry_t e);
        issue_entry_t r;
        r = e;
        if (r.rs1_tag != '0 && !tag_pending[r.rs1_tag]) begin
            r.rs1_val = tag_value[r.rs1_tag];
            r.rs1_tag = '0;
        end
        if (r.rs2_tag != '0 && !tag_pending[r.rs2_tag]) begin
            r.rs2_val = tag_value[r.rs2_tag];
            r.rs2_tag = '0;
        end
        return r;
    endfunction

    task automatic pick_operand(input logic use_dep, input rob_tag_t src, output data_t val,
                                output rob_tag_t tag, output data_t expect_val);
        val = take_bits(32);  // Junk while a tag is pending.
        tag = '0;
        expect_val = val;
        if (use_dep && src != '0) begin
            expect_val = tag_value[src];
            if (tag_pending[src]) tag = src;
            else val = tag_value[src];
        end
    endtask

    task automatic observe_cdb();
        if (cdb.valid === 1'b1) begin
            if (!tag_pending[cdb.rob_tag]) begin
                tag_errors++;
                $display("Broadcast of tag %0d, which has no pending op", cdb.rob_tag);
            end else begin
                if (cdb.result !== tag_value[cdb.rob_tag]) begin
                    value_errors++;
                    $display("FAILED cdb.result for tag 0x%h: got 0x%h, expected 0x%h",
                             cdb.rob_tag, cdb.result, tag_value[cdb.rob_tag]);
                end
                tag_pending[cdb.rob_tag] = 1'b0;
                if (tag_is_mem[cdb.rob_tag]) addr_busy[tag_addr[cdb.rob_tag]] = 1'b0;
                completed++;
            end
        end
    endtask

    task automatic check_quiet(input string when_text);
        if (cdb.valid !== 1'b0) begin
            other_errors++;
            $display("FAILED cdb.valid %s: got 0x%h, expected 0x0", when_text, cdb.valid);
        end
        if (issue_ready !== 1'b1) begin
            other_errors++;
            $display("FAILED issue_ready %s: got 0x%h, expected 0x1", when_text, issue_ready);
        end
    endtask

    // ####################
    // Issue driver
    // ####################
    task automatic idle_cycle();
        @(negedge clk_in);
        issue_valid = 1'b0;
        observe_cdb();
    endtask

    task automatic drain();
        while (tag_pending != '0) idle_cycle();
    endtask

    // Holds the op on the port until the station takes it.
    task automatic present(input issue_entry_t e);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk_in);
            e = resolve(e);
            issue = e;
            issue_valid = 1'b1;
            taken = issue_ready;
            observe_cdb();
        end
        issued++;
    endtask

    task automatic send_random(input int mem_odds, input logic dep_ok);
        issue_entry_t e;
        data_t a;
        data_t b;
        data_t sum;
        logic [31:0] r;
        rob_tag_t t;
        logic is_mem;
        logic [3:0] addr;
        e = '0;
        is_mem = take_bits(2) < mem_odds;
        e.op_class = is_mem ? class_mem : class_alu;
        r = take_bits(3);
        e.op.alu = alu_func_t'(r[2:0]);
        if (is_mem) e.op.mem.spare = 2'b00;
        e.imm = take_bits(32);
        e.pc = take_bits(32);
        pick_operand(dep_ok && take_bits(1) != 0, last_tag, e.rs1_val, e.rs1_tag, a);
        r = take_bits(4);
        pick_operand(dep_ok && take_bits(1) != 0, r[3:0], e.rs2_val, e.rs2_tag, b);
        sum = a + e.imm;
        addr = sum[3:0];
        while (free_tag() == '0 || (is_mem && addr_busy[addr])) idle_cycle();
        e = resolve(e);
        t = free_tag();
        e.rob_tag = t;
        if (!is_mem) begin
            tag_value[t] = alu_expect(e.op.alu, a, b);
        end else if (e.op.mem.func == mem_store) begin
            mem_model[addr] = b;
            tag_value[t] = '0;
        end else begin
            tag_value[t] = mem_model[addr];
        end
        tag_pending[t] = 1'b1;
        tag_is_mem[t] = is_mem;
        tag_addr[t] = addr;
        if (is_mem) addr_busy[addr] = 1'b1;
        last_tag = t;
        present(e);
    endtask

    // One flush cycle, after which nothing queued may survive.
    task automatic pulse_flush();
        @(negedge clk_in);
        flush = 1'b1;
        observe_cdb();
        @(negedge clk_in);
        flush = 1'b0;
        tag_pending = '0;  // Every queued op is gone.
        addr_busy = '0;
        last_tag = '0;
        check_quiet("after flush");
    endtask

    // Eight ops wait on a tag that never issues, then flush.
    task automatic fill_and_flush();
        issue_entry_t e;
        rob_tag_t hold_tag;
        logic [31:0] r;
        drain();
        hold_tag = free_tag();
        tag_pending[hold_tag] = 1'b1;
        for (int i = 0; i < rs_size; i++) begin
            e = '0;
            e.rob_tag = free_tag();
            r = take_bits(4);
            e.op_class = r[3] ? class_mem : class_alu;
            e.op.alu = alu_func_t'(r[2:0]);
            if (r[3]) e.op.mem.spare = 2'b00;
            e.rs1_tag = hold_tag;
            e.rs2_val = take_bits(32);
            tag_pending[e.rob_tag] = 1'b1;
            tag_is_mem[e.rob_tag] = 1'b0;
            @(negedge clk_in);
            if (issue_ready !== 1'b1) begin
                other_errors++;
                $display("FAILED issue_ready with %0d ops waiting: got 0x%h, expected 0x1",
                         i, issue_ready);
            end
            issue = e;
            issue_valid = 1'b1;
            observe_cdb();
        end
        repeat (3) begin
            idle_cycle();
            if (issue_ready !== 1'b0) begin
                other_errors++;
                $display("FAILED issue_ready with a full station: got 0x%h, expected 0x0",
                         issue_ready);
            end
        end
        pulse_flush();

        // A ready op on its way into the ALU when the next flush hits.
        e = '0;
        e.rob_tag = free_tag();
        r = take_bits(3);
        e.op.alu = alu_func_t'(r[2:0]);
        e.rs1_val = take_bits(32);
        e.rs2_val = take_bits(32);
        tag_pending[e.rob_tag] = 1'b1;
        tag_is_mem[e.rob_tag] = 1'b0;
        issue = e;
        issue_valid = 1'b1;
        idle_cycle();
        pulse_flush();
    endtask

    // ####################
    // Test sequence
    // ####################
    initial begin
        reset = 1'b1;
        flush = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        lfsr_state = 32'h7cdb4643;
        tag_pending = '0;
        tag_is_mem = '0;
        addr_busy = '0;
        last_tag = '0;
        for (int i = 0; i < 16; i++) begin
            tag_value[i] = '0;
            tag_addr[i] = '0;
            mem_model[i] = '0;
        end
        value_errors = 0;
        tag_errors = 0;
        other_errors = 0;
        issued = 0;
        completed = 0;
        cycle_count = 0;
        repeat (16) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;
        @(negedge clk_in);
        check_quiet("after reset");

        for (int i = 0; i < value_ops; i++) send_random(0, 1'b0);
        drain();
        for (int i = 0; i < chain_ops; i++) send_random(0, 1'b1);
        for (int i = 0; i < memory_ops; i++) send_random(3, 1'b1);
        for (int i = 0; i < mixed_ops; i++) send_random(1, 1'b1);
        fill_and_flush();
        for (int i = 0; i < after_ops; i++) send_random(2, 1'b1);
        drain();
        repeat (10) idle_cycle();  // Catches late duplicates.

        if (completed != issued) begin
            other_errors++;
            $display("Only %0d of %0d issued ops completed", completed, issued);
        end
        $display("Issued %0d, completed %0d, value errors %0d, tag errors %0d, other errors %0d",
                 issued, completed, value_errors, tag_errors, other_errors);
        if (value_errors + tag_errors + other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
common/tomasulo_pkg.sv
reservation_station/reservation_station.sv
design/alu_unit.sv
design/load_store_buffer.sv
design/cdb_arbiter.sv
design/exec_core.sv
sim/tb_exec_core.sv

/* run_sim.sh */
#!/bin/sh
# Builds the exec_core testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_exec_core \
    -o tb_exec_core \
    && ./obj_dir/tb_exec_core | tee sim.log \
    || { echo "Build or run failed"; exit 1; }

grep -q '^\*\* PASS \*\*$' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
